/* src/shoot_pkg.sv */
/* shared geometry, colours, state types and timing constants of the shooter side
   every design file refers to these by scoped name */
`default_nettype none

package shoot_pkg;

    localparam int COORD_W = 12;
    localparam int PIX_W   = 11;
    localparam int RGB_W   = 12;
    localparam int KPOS_W  = 10;

    // keeper box, x in keeper units, y in screen rows
    localparam logic [KPOS_W-1:0] GK_FIXED_LEFT = 10'd400;
    localparam logic [KPOS_W-1:0] GK_HALF_WIDTH = 10'd100;
    localparam logic [PIX_W-1:0]  GK_TOP_Y      = 11'd250;
    localparam logic [PIX_W-1:0]  GK_BOTTOM_Y   = 11'd550;
    localparam logic [KPOS_W-1:0] GK_MIN_CENTRE = 10'd255;
    localparam logic [KPOS_W-1:0] GK_MAX_CENTRE = 10'd769;

    // goal mouth, cursor coordinates
    localparam logic [COORD_W-1:0] SCREEN_WIDTH  = 12'd1024;
    localparam logic [COORD_W-1:0] POST_INNER_X  = 12'd112;
    localparam logic [COORD_W-1:0] CROSSBAR_Y    = 12'd150;
    localparam logic [COORD_W-1:0] POST_BOTTOM_Y = 12'd600;

    localparam logic [RGB_W-1:0] COL_AIM  = 12'h00F;  // blue
    localparam logic [RGB_W-1:0] COL_GOAL = 12'h0F0;  // green
    localparam logic [RGB_W-1:0] COL_MISS = 12'hF00;  // red

    // verdict from the other board must sit high this long
    localparam int                      ENEMY_CNT_W  = 4;
    localparam logic [ENEMY_CNT_W-1:0]  ENEMY_STABLE = 4'd11;

    localparam int HOLD_CYCLES_DEF = 13_003_902;

    typedef enum logic [2:0] {
        IDLE,
        ENGAGE,
        AIM,
        RESULT,
        GOAL,
        MISS,
        TERMINATE
    } shoot_state_e;

    typedef enum logic [1:0] {
        KC_NONE,
        KC_AIM,
        KC_GOAL,
        KC_MISS
    } keeper_col_e;

endpackage

`default_nettype wire

/* src/vga_if.sv */
/* one pixel stream with its counters, syncs and blanking, one pixel per clock
   producers use the out modport, consumers the in modport */
`timescale 1ns/1ns
`default_nettype none

interface vga_if;

    logic [shoot_pkg::PIX_W-1:0] hcount;
    logic [shoot_pkg::PIX_W-1:0] vcount;
    logic                        hsync;
    logic                        vsync;
    logic                        hblnk;
    logic                        vblnk;
    logic [shoot_pkg::RGB_W-1:0] rgb;

    modport in (
        input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

    modport out (
        output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

endinterface

`default_nettype wire

/* src/shoot_fsm.sv */
/* sequences one penalty shot from turn start to round end, runs the hold timer
   and turns the state into the keeper colour select and the round strobes */
`timescale 1ns/1ns
`default_nettype none

module shoot_fsm #(
    parameter int unsigned hold_cycles = shoot_pkg::HOLD_CYCLES_DEF
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   shooter_active,
    input  logic                   multi,
    input  logic                   left_clicked,
    input  logic                   scored_local,
    input  logic                   enemy_ready,
    input  logic                   enemy_scored,
    output shoot_pkg::keeper_col_e keeper_col,
    output logic                   is_scored,
    output logic                   round_done,
    output logic                   end_sh,
    output logic                   shot_taken
);

    shoot_pkg::shoot_state_e state, state_nxt;
    shoot_pkg::keeper_col_e  col_nxt;

    logic [$clog2(hold_cycles + 1)-1:0] hold_cnt;
    logic                               hold_run;
    logic                               hold_done;

    assign hold_done = (hold_cnt == ($bits(hold_cnt))'(hold_cycles - 1));

    // timer runs through both result states and the long multi wind-down
    assign hold_run = (state == shoot_pkg::GOAL) || (state == shoot_pkg::MISS) ||
                      ((state == shoot_pkg::TERMINATE) && multi);

    always_comb begin
        state_nxt = state;
        unique case (state)
            shoot_pkg::IDLE: begin
                if (shooter_active)
                    state_nxt = shoot_pkg::ENGAGE;
            end
            shoot_pkg::ENGAGE: begin  // turn must still be ours
                state_nxt = shooter_active ? shoot_pkg::AIM : shoot_pkg::IDLE;
            end
            shoot_pkg::AIM: begin
                if (left_clicked)
                    state_nxt = shoot_pkg::RESULT;
            end
            shoot_pkg::RESULT: begin
                if (!multi)
                    state_nxt = scored_local ? shoot_pkg::GOAL : shoot_pkg::MISS;
                else if (enemy_ready)
                    state_nxt = enemy_scored ? shoot_pkg::GOAL : shoot_pkg::MISS;
            end
            shoot_pkg::GOAL, shoot_pkg::MISS: begin
                if (hold_done)
                    state_nxt = shoot_pkg::TERMINATE;
            end
            shoot_pkg::TERMINATE: begin
                if (!multi || hold_done)
                    state_nxt = shoot_pkg::IDLE;
            end
            default: state_nxt = shoot_pkg::IDLE;
        endcase
    end

    always_comb begin
        unique case (state)
            shoot_pkg::AIM, shoot_pkg::RESULT: col_nxt = shoot_pkg::KC_AIM;
            shoot_pkg::GOAL:                   col_nxt = shoot_pkg::KC_GOAL;
            shoot_pkg::MISS:                   col_nxt = shoot_pkg::KC_MISS;
            default:                           col_nxt = shoot_pkg::KC_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= shoot_pkg::IDLE;
            hold_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (!hold_run || hold_done)
                hold_cnt <= '0;
            else
                hold_cnt <= hold_cnt + 1'b1;
        end
    end

    // outputs lag the state by one clock
    always_ff @(posedge clk) begin
        if (rst) begin
            keeper_col <= shoot_pkg::KC_NONE;
            is_scored  <= 1'b0;
            round_done <= 1'b0;
            end_sh     <= 1'b0;
            shot_taken <= 1'b0;
        end else begin
            keeper_col <= col_nxt;
            is_scored  <= !multi && (state == shoot_pkg::GOAL);
            round_done <= !multi && (state == shoot_pkg::TERMINATE);
            end_sh     <= (state == shoot_pkg::TERMINATE) && (!multi || hold_done);
            shot_taken <= multi && (state == shoot_pkg::RESULT);  // waiting on the other board
        end
    end

endmodule

`default_nettype wire

/* src/keeper_tracker.sv */
/* keeper edges for drawing and judging, fixed in solo play and following the
   other player's keeper position, clamped to the goal, in multi play */
`timescale 1ns/1ns
`default_nettype none

module keeper_tracker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         multi,
    input  logic [shoot_pkg::KPOS_W-1:0] keeper_pos,
    output logic [shoot_pkg::KPOS_W-1:0] gk_left,
    output logic [shoot_pkg::KPOS_W-1:0] gk_right
);

    logic [shoot_pkg::KPOS_W-1:0] centre;

    always_comb begin
        if (keeper_pos < shoot_pkg::GK_MIN_CENTRE)
            centre = shoot_pkg::GK_MIN_CENTRE;
        else if (keeper_pos > shoot_pkg::GK_MAX_CENTRE)
            centre = shoot_pkg::GK_MAX_CENTRE;
        else
            centre = keeper_pos;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gk_left  <= '0;
            gk_right <= '0;
        end else if (multi) begin
            gk_left  <= centre - shoot_pkg::GK_HALF_WIDTH;
            gk_right <= centre + shoot_pkg::GK_HALF_WIDTH;
        end else begin
            gk_left  <= shoot_pkg::GK_FIXED_LEFT;
            gk_right <= shoot_pkg::GK_FIXED_LEFT + shoot_pkg::GK_HALF_WIDTH +
                        shoot_pkg::GK_HALF_WIDTH;
        end
    end

endmodule

`default_nettype wire

/* src/shot_judge.sv */
/* solo verdict registered every clock from the cursor position
   a goal needs the cursor inside the goal mouth and off the keeper */
`timescale 1ns/1ns
`default_nettype none

module shot_judge (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [shoot_pkg::COORD_W-1:0] xpos,
    input  logic [shoot_pkg::COORD_W-1:0] ypos,
    input  logic [shoot_pkg::KPOS_W-1:0]  gk_left,
    input  logic [shoot_pkg::KPOS_W-1:0]  gk_right,
    output logic                          scored_local
);

    logic [shoot_pkg::COORD_W-1:0] kx_lo, kx_hi;
    logic                          in_mouth;
    logic                          on_keeper;

    // keeper box widened to cursor coordinates
    assign kx_lo = {{(shoot_pkg::COORD_W - shoot_pkg::KPOS_W){1'b0}}, gk_left};
    assign kx_hi = {{(shoot_pkg::COORD_W - shoot_pkg::KPOS_W){1'b0}}, gk_right};

    assign in_mouth = (xpos >= shoot_pkg::POST_INNER_X) &&
                      (xpos <= shoot_pkg::SCREEN_WIDTH - shoot_pkg::POST_INNER_X) &&
                      (ypos >= shoot_pkg::CROSSBAR_Y) && (ypos <= shoot_pkg::POST_BOTTOM_Y);

    assign on_keeper = (xpos >= kx_lo) && (xpos <= kx_hi) &&
        (ypos >= {{(shoot_pkg::COORD_W - shoot_pkg::PIX_W){1'b0}}, shoot_pkg::GK_TOP_Y}) &&
        (ypos <= {{(shoot_pkg::COORD_W - shoot_pkg::PIX_W){1'b0}}, shoot_pkg::GK_BOTTOM_Y});

    always_ff @(posedge clk) begin
        if (rst)
            scored_local <= 1'b0;
        else
            scored_local <= in_mouth && !on_keeper;
    end

endmodule

`default_nettype wire

/* src/enemy_result_filter.sv */
/* debounces the verdict flag coming from the other board
   enemy_ready pulses once the flag has stayed high long enough */
`timescale 1ns/1ns
`default_nettype none

module enemy_result_filter (
    input  logic clk,
    input  logic rst,
    input  logic enemy_input,
    input  logic enemy_is_scored,
    output logic enemy_ready,
    output logic enemy_scored
);

    logic [shoot_pkg::ENEMY_CNT_W-1:0] stable_cnt;
    logic                              stable_hit;

    assign stable_hit = enemy_input && (stable_cnt == shoot_pkg::ENEMY_STABLE - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            stable_cnt  <= '0;
            enemy_ready <= 1'b0;
        end else begin
            enemy_ready <= stable_hit;
            if (!enemy_input || stable_hit)
                stable_cnt <= '0;  // glitch or accepted, start over
            else
                stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // verdict captured together with the ready pulse
    always_ff @(posedge clk) begin
        if (stable_hit)
            enemy_scored <= enemy_is_scored;
    end

endmodule

`default_nettype wire

/* src/keeper_overlay.sv */
/* single register stage on the video stream that paints the keeper box
   in the colour picked by the control FSM, all other pixels pass unchanged */
`timescale 1ns/1ns
`default_nettype none

module keeper_overlay (
    input  logic                         clk,
    input  logic                         rst,
    vga_if.in                            vid_in,
    input  logic [shoot_pkg::KPOS_W-1:0] gk_left,
    input  logic [shoot_pkg::KPOS_W-1:0] gk_right,
    input  shoot_pkg::keeper_col_e       keeper_col,
    vga_if.out                           vid_out
);

    logic [shoot_pkg::PIX_W-1:0] box_l, box_r;
    logic                        in_box;
    logic [shoot_pkg::RGB_W-1:0] rgb_nxt;

    assign box_l = {{(shoot_pkg::PIX_W - shoot_pkg::KPOS_W){1'b0}}, gk_left};
    assign box_r = {{(shoot_pkg::PIX_W - shoot_pkg::KPOS_W){1'b0}}, gk_right};

    assign in_box = (vid_in.hcount >= box_l) && (vid_in.hcount <= box_r) &&
                    (vid_in.vcount >= shoot_pkg::GK_TOP_Y) &&
                    (vid_in.vcount <= shoot_pkg::GK_BOTTOM_Y);

    always_comb begin
        rgb_nxt = vid_in.rgb;
        if (in_box) begin
            unique case (keeper_col)
                shoot_pkg::KC_AIM:  rgb_nxt = shoot_pkg::COL_AIM;
                shoot_pkg::KC_GOAL: rgb_nxt = shoot_pkg::COL_GOAL;
                shoot_pkg::KC_MISS: rgb_nxt = shoot_pkg::COL_MISS;
                default:            rgb_nxt = vid_in.rgb;  // keeper hidden
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vid_out.hcount <= '0;
            vid_out.vcount <= '0;
            vid_out.hsync  <= 1'b0;
            vid_out.vsync  <= 1'b0;
            vid_out.hblnk  <= 1'b0;
            vid_out.vblnk  <= 1'b0;
            vid_out.rgb    <= '0;
        end else begin
            vid_out.hcount <= vid_in.hcount;
            vid_out.vcount <= vid_in.vcount;
            vid_out.hsync  <= vid_in.hsync;
            vid_out.vsync  <= vid_in.vsync;
            vid_out.hblnk  <= vid_in.hblnk;
            vid_out.vblnk  <= vid_in.vblnk;
            vid_out.rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

/* src/shoot_top.sv */
/* shooter side of the two-board penalty game, keeper drawn over the incoming video
   set hold_cycles to the length of the result and wind-down periods */
`timescale 1ns/1ns
`default_nettype none

module shoot_top #(
    parameter int unsigned hold_cycles = shoot_pkg::HOLD_CYCLES_DEF
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          shooter_active,
    input  logic                          multi,
    input  logic                          left_clicked,
    input  logic                          enemy_input,
    input  logic                          enemy_is_scored,
    input  logic [shoot_pkg::COORD_W-1:0] xpos,
    input  logic [shoot_pkg::COORD_W-1:0] ypos,
    input  logic [shoot_pkg::KPOS_W-1:0]  keeper_pos,
    input  logic [shoot_pkg::PIX_W-1:0]   hcount_in,
    input  logic [shoot_pkg::PIX_W-1:0]   vcount_in,
    input  logic                          hsync_in,
    input  logic                          vsync_in,
    input  logic                          hblnk_in,
    input  logic                          vblnk_in,
    input  logic [shoot_pkg::RGB_W-1:0]   rgb_in,
    output logic [shoot_pkg::PIX_W-1:0]   hcount_out,
    output logic [shoot_pkg::PIX_W-1:0]   vcount_out,
    output logic                          hsync_out,
    output logic                          vsync_out,
    output logic                          hblnk_out,
    output logic                          vblnk_out,
    output logic [shoot_pkg::RGB_W-1:0]   rgb_out,
    output logic                          is_scored,
    output logic                          round_done,
    output logic                          end_sh,
    output logic                          shot_taken
);

    vga_if vid_in_if ();
    vga_if vid_out_if ();

    logic [shoot_pkg::KPOS_W-1:0] gk_left, gk_right;
    logic                         scored_local;
    logic                         enemy_ready, enemy_scored;
    shoot_pkg::keeper_col_e       keeper_col;

    assign vid_in_if.hcount = hcount_in;
    assign vid_in_if.vcount = vcount_in;
    assign vid_in_if.hsync  = hsync_in;
    assign vid_in_if.vsync  = vsync_in;
    assign vid_in_if.hblnk  = hblnk_in;
    assign vid_in_if.vblnk  = vblnk_in;
    assign vid_in_if.rgb    = rgb_in;

    assign hcount_out = vid_out_if.hcount;
    assign vcount_out = vid_out_if.vcount;
    assign hsync_out  = vid_out_if.hsync;
    assign vsync_out  = vid_out_if.vsync;
    assign hblnk_out  = vid_out_if.hblnk;
    assign vblnk_out  = vid_out_if.vblnk;
    assign rgb_out    = vid_out_if.rgb;

    shoot_fsm #(.hold_cycles(hold_cycles)) u_fsm (
        .clk, .rst, .shooter_active, .multi, .left_clicked,
        .scored_local, .enemy_ready, .enemy_scored,
        .keeper_col, .is_scored, .round_done, .end_sh, .shot_taken
    );

    keeper_tracker u_tracker (.clk, .rst, .multi, .keeper_pos, .gk_left, .gk_right);

    shot_judge u_judge (.clk, .rst, .xpos, .ypos, .gk_left, .gk_right, .scored_local);

    enemy_result_filter u_enemy (
        .clk, .rst, .enemy_input, .enemy_is_scored, .enemy_ready, .enemy_scored
    );

    keeper_overlay u_overlay (
        .clk, .rst, .vid_in(vid_in_if.in), .gk_left, .gk_right, .keeper_col,
        .vid_out(vid_out_if.out)
    );

endmodule

`default_nettype wire

/* tb/shoot_top_props.sv */
/* concurrent checks on the round strobes of the control FSM
   bound into shoot_fsm and sampled on its clock */
`timescale 1ns/1ns
`default_nettype none

module shoot_top_props (
    input logic clk,
    input logic rst,
    input logic multi,
    input logic is_scored,
    input logic round_done,
    input logic end_sh,
    input logic shot_taken
);

    int unsigned fail_cnt = 0;

    end_sh_single: assert property (@(posedge clk) disable iff (rst) end_sh |=> !end_sh)
        else begin
            fail_cnt++;
            $error("end_sh held longer than one cycle");
        end

    scored_vs_waiting: assert property (@(posedge clk) disable iff (rst)
        !(is_scored && shot_taken))
        else begin
            fail_cnt++;
            $error("is_scored and shot_taken high together");
        end

    // mode stays put for the whole round
    no_round_done_multi: assert property (@(posedge clk) disable iff (rst)
        $rose(round_done) |-> !multi)
        else begin
            fail_cnt++;
            $error("round_done rose in multi mode");
        end

endmodule

bind shoot_fsm shoot_top_props u_props (
    .clk, .rst, .multi, .is_scored, .round_done, .end_sh, .shot_taken
);

`default_nettype wire

/* tb/shoot_top_tb.sv */
/* testbench for the shooter side: random video walk under scripted solo and multi turns,
   every video output and strobe compared each cycle with a cycle model of the game rules */
`timescale 1ns/1ns
`default_nettype none

module shoot_top_tb;

    localparam int HOLD         = 20;
    localparam int CLK_PERIOD   = 10;
    localparam int H_TOTAL      = 1344;
    localparam int V_TOTAL      = 806;
    localparam int AIM_WAIT     = 150;
    localparam int N_TURNS      = 8;
    localparam int LONGEST_TURN = AIM_WAIT + 4 * HOLD + 60;  // multi turn with bursts
    localparam int WATCHDOG_CYC = N_TURNS * LONGEST_TURN + 200;

    logic        clk, rst;
    logic        shooter_active, multi, left_clicked, enemy_input, enemy_is_scored;
    logic [11:0] xpos, ypos;
    logic [9:0]  keeper_pos;
    logic [10:0] hcount_in, vcount_in, hcount_out, vcount_out;
    logic        hsync_in, vsync_in, hblnk_in, vblnk_in;
    logic        hsync_out, vsync_out, hblnk_out, vblnk_out;
    logic [11:0] rgb_in, rgb_out;
    logic        is_scored, round_done, end_sh, shot_taken;

    // cycle model registers
    shoot_pkg::shoot_state_e m_state;
    shoot_pkg::keeper_col_e  m_col;
    int          m_hold;
    logic [19:0] m_edges;  // {left, right}
    logic        m_scored_local;
    int          m_enemy_cnt;
    logic        m_enemy_ready, m_enemy_scored;
    logic [10:0] x_hcount, x_vcount;
    logic        x_hsync, x_vsync, x_hblnk, x_vblnk;
    logic [11:0] x_rgb;
    logic        x_is_scored, x_round_done, x_end_sh, x_shot_taken;

    logic [31:0] lfsr_state = 32'd84152;
    int err_cnt = 0;
    int n_is_scored = 0, n_round_done = 0, n_end_sh = 0, n_shot_taken = 0;
    int b_is_scored, b_round_done, b_end_sh, b_shot_taken;

    shoot_top #(.hold_cycles(HOLD)) u_dut (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);  // taps 32 30 26 25
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [19:0] keeper_edges(input logic m, input int pos);
        int c;
        c = (pos < 255) ? 255 : ((pos > 769) ? 769 : pos);
        if (!m)
            return {10'd400, 10'd600};
        return {10'(c - 100), 10'(c + 100)};
    endfunction

    function automatic logic in_keeper(input int x, input int y, input int l, input int r);
        return (x >= l) && (x <= r) && (y >= 250) && (y <= 550);
    endfunction

    function automatic logic goal_rule(input int x, input int y, input int l, input int r);
        logic in_mouth;
        in_mouth = (x >= 112) && (x <= 1024 - 112) && (y >= 150) && (y <= 600);
        return in_mouth && !in_keeper(x, y, l, r);
    endfunction

    function automatic logic [11:0] pixel_rgb(input int hc, input int vc, input logic [11:0] rgb,
                                              input shoot_pkg::keeper_col_e col,
                                              input int l, input int r);
        if (!in_keeper(hc, vc, l, r))
            return rgb;
        case (col)
            shoot_pkg::KC_AIM:  return 12'h00F;
            shoot_pkg::KC_GOAL: return 12'h0F0;
            shoot_pkg::KC_MISS: return 12'hF00;
            default:            return rgb;
        endcase
    endfunction

    // held counts the cycles already spent in the current state
    function automatic shoot_pkg::shoot_state_e next_state(
        input shoot_pkg::shoot_state_e s, input logic act, input logic m, input logic click,
        input logic local_goal, input logic e_ready, input logic e_goal, input int held);
        case (s)
            shoot_pkg::IDLE:   return act ? shoot_pkg::ENGAGE : shoot_pkg::IDLE;
            shoot_pkg::ENGAGE: return act ? shoot_pkg::AIM : shoot_pkg::IDLE;
            shoot_pkg::AIM:    return click ? shoot_pkg::RESULT : shoot_pkg::AIM;
            shoot_pkg::RESULT: begin
                if (!m)
                    return local_goal ? shoot_pkg::GOAL : shoot_pkg::MISS;
                if (e_ready)
                    return e_goal ? shoot_pkg::GOAL : shoot_pkg::MISS;
                return shoot_pkg::RESULT;
            end
            shoot_pkg::GOAL, shoot_pkg::MISS:
                return (held == HOLD - 1) ? shoot_pkg::TERMINATE : s;
            shoot_pkg::TERMINATE:
                return (!m || held == HOLD - 1) ? shoot_pkg::IDLE : shoot_pkg::TERMINATE;
            default: return shoot_pkg::IDLE;
        endcase
    endfunction

    always @(posedge clk) begin : ref_model
        shoot_pkg::shoot_state_e nxt;
        int enemy_nxt;
        nxt = next_state(m_state, shooter_active, multi, left_clicked, m_scored_local,
                         m_enemy_ready, m_enemy_scored, m_hold);
        enemy_nxt = enemy_input ? m_enemy_cnt + 1 : 0;
        if (rst) begin
            m_state        <= shoot_pkg::IDLE;
            m_col          <= shoot_pkg::KC_NONE;
            m_hold         <= 0;
            m_edges        <= '0;
            m_scored_local <= 1'b0;
            m_enemy_cnt    <= 0;
            m_enemy_ready  <= 1'b0;
            {x_hcount, x_vcount, x_hsync, x_vsync, x_hblnk, x_vblnk, x_rgb} <= '0;
            {x_is_scored, x_round_done, x_end_sh, x_shot_taken} <= '0;
        end else begin
            m_state        <= nxt;
            m_hold         <= (nxt == m_state) ? m_hold + 1 : 0;
            m_edges        <= keeper_edges(multi, keeper_pos);
            m_scored_local <= goal_rule(xpos, ypos, m_edges[19:10], m_edges[9:0]);
            m_enemy_ready  <= (enemy_nxt == 11);
            m_enemy_cnt    <= (enemy_nxt == 11) ? 0 : enemy_nxt;
            if (enemy_nxt == 11)
                m_enemy_scored <= enemy_is_scored;
            case (m_state)
                shoot_pkg::AIM, shoot_pkg::RESULT: m_col <= shoot_pkg::KC_AIM;
                shoot_pkg::GOAL:                   m_col <= shoot_pkg::KC_GOAL;
                shoot_pkg::MISS:                   m_col <= shoot_pkg::KC_MISS;
                default:                           m_col <= shoot_pkg::KC_NONE;
            endcase
            x_hcount <= hcount_in;
            x_vcount <= vcount_in;
            {x_hsync, x_vsync, x_hblnk, x_vblnk} <= {hsync_in, vsync_in, hblnk_in, vblnk_in};
            x_rgb <= pixel_rgb(hcount_in, vcount_in, rgb_in, m_col, m_edges[19:10], m_edges[9:0]);
            x_is_scored  <= !multi && (m_state == shoot_pkg::GOAL);
            x_round_done <= !multi && (m_state == shoot_pkg::TERMINATE);
            x_end_sh     <= (m_state == shoot_pkg::TERMINATE) && (nxt == shoot_pkg::IDLE);
            x_shot_taken <= multi && (m_state == shoot_pkg::RESULT);
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t ns %s: got %h, expected %h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1, "mismatch");
        end
    endtask

    initial begin : compare
        @(posedge clk);
        forever begin
            @(negedge clk);
            check_val("hcount_out", hcount_out, x_hcount);
            check_val("vcount_out", vcount_out, x_vcount);
            check_val("hsync_out", hsync_out, x_hsync);
            check_val("vsync_out", vsync_out, x_vsync);
            check_val("hblnk_out", hblnk_out, x_hblnk);
            check_val("vblnk_out", vblnk_out, x_vblnk);
            check_val("rgb_out", rgb_out, x_rgb);
            check_val("is_scored", is_scored, x_is_scored);
            check_val("round_done", round_done, x_round_done);
            check_val("end_sh", end_sh, x_end_sh);
            check_val("shot_taken", shot_taken, x_shot_taken);
            check_val("assertion failures", u_dut.u_fsm.u_props.fail_cnt, 0);
            n_is_scored  += int'(is_scored);
            n_round_done += int'(round_done);
            n_end_sh     += int'(end_sh);
            n_shot_taken += int'(shot_taken);
        end
    end

    initial begin : video_drive
        int hpos;
        int vpos;
        logic [31:0] bits;
        hpos = 0;
        vpos = 0;
        {hcount_in, vcount_in, hsync_in, vsync_in, hblnk_in, vblnk_in} = '0;
        rgb_in     = '0;
        keeper_pos = '0;
        forever begin
            @(negedge clk);
            // strided walk, short hold periods still cross the keeper rows
            hpos = (hpos + 97) % H_TOTAL;
            vpos = (vpos + 61) % V_TOTAL;
            hcount_in = 11'(hpos);
            vcount_in = 11'(vpos);
            hblnk_in  = (hpos >= 1024);
            hsync_in  = (hpos >= 1048) && (hpos < 1184);
            vblnk_in  = (vpos >= 768);
            vsync_in  = (vpos >= 771) && (vpos < 777);
            take_bits(12, bits);
            rgb_in = bits[11:0];
            take_bits(10, bits);
            keeper_pos = bits[9:0];
        end
    end

    task automatic mark_counts();
        b_is_scored  = n_is_scored;
        b_round_done = n_round_done;
        b_end_sh     = n_end_sh;
        b_shot_taken = n_shot_taken;
    endtask

    task automatic expect_counts(input int sc, input int rd, input int es, input logic shot);
        check_val("is_scored cycles", n_is_scored - b_is_scored, sc);
        check_val("round_done pulses", n_round_done - b_round_done, rd);
        check_val("end_sh pulses", n_end_sh - b_end_sh, es);
        check_val("shot_taken seen", (n_shot_taken - b_shot_taken) > 0, shot);
    endtask

    task automatic wait_end_sh();
        int waited;
        waited = 0;
        while (end_sh !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > LONGEST_TURN) begin
                $display("end_sh did not arrive within %0d cycles of the click", LONGEST_TURN);
                $display("Errors found");
                $fatal(1, "no end of round");
            end
        end
    endtask

    task automatic burst(input int len);
        enemy_input = 1'b1;
        repeat (len) @(negedge clk);
        enemy_input = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic feed_enemy(input logic goal);
        enemy_is_scored = !goal;  // short bursts carry the wrong verdict
        burst(5);
        burst(10);
        check_val("shot_taken", shot_taken, 1'b1);
        enemy_is_scored = goal;
        burst(12);
    endtask

    task automatic play_turn(input logic m, input logic [11:0] x, input logic [11:0] y,
                             input logic enemy_goal, input int exp_scored, input int exp_done);
        @(posedge clk);
        mark_counts();
        @(negedge clk);
        multi = m;
        xpos  = x;
        ypos  = y;
        shooter_active = 1'b1;
        repeat (2) @(negedge clk);
        shooter_active = 1'b0;
        repeat (AIM_WAIT) @(negedge clk);
        left_clicked = 1'b1;
        @(negedge clk);
        left_clicked = 1'b0;
        if (m)
            feed_enemy(enemy_goal);
        wait_end_sh();
        repeat (3) @(negedge clk);
        @(posedge clk);
        expect_counts(exp_scored, exp_done, 1, m);
    endtask

    task automatic abort_turn();
        @(posedge clk);
        mark_counts();
        @(negedge clk);
        shooter_active = 1'b1;
        @(negedge clk);
        shooter_active = 1'b0;  // gone before ENGAGE is left
        repeat (10) @(negedge clk);
        @(posedge clk);
        expect_counts(0, 0, 0, 1'b0);
    endtask

    initial begin : scenario
        rst = 1'b1;
        {shooter_active, multi, left_clicked, enemy_input, enemy_is_scored} = '0;
        xpos = '0;
        ypos = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk);
        play_turn(1'b0, 12'd200, 12'd300, 1'b0, HOLD, 1);  // beside the keeper
        play_turn(1'b0, 12'd500, 12'd400, 1'b0, 0, 1);     // straight at him
        play_turn(1'b0, 12'd50, 12'd300, 1'b0, 0, 1);      // wide of the post
        abort_turn();
        play_turn(1'b1, 12'd0, 12'd0, 1'b1, 0, 0);
        play_turn(1'b1, 12'd0, 12'd0, 1'b0, 0, 0);
        play_turn(1'b0, 12'd912, 12'd600, 1'b0, HOLD, 1);  // far corner of the mouth
        play_turn(1'b0, 12'd600, 12'd550, 1'b0, 0, 1);     // keeper's corner
        if (err_cnt == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "checks failed");
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("timeout: turns still running after %0d cycles", WATCHDOG_CYC);
        $display("Errors found");
        $fatal(1, "watchdog");
    end

endmodule

`default_nettype wire

/* shoot_top.f */
src/shoot_pkg.sv
src/vga_if.sv
src/shoot_fsm.sv
src/keeper_tracker.sv
src/shot_judge.sv
src/enemy_result_filter.sv
src/keeper_overlay.sv
src/shoot_top.sv
tb/shoot_top_props.sv
tb/shoot_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f shoot_top.f \
    --top-module shoot_top_tb -Mdir obj_dir -o sim_shoot_top
./obj_dir/sim_shoot_top +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -qx "No errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
